// File: Bender.yml
package:
  name: la32_core

sources:
  - include_dirs:
      - design
    files:
      - design/la32_pkg.sv
      - design/inst_decoder.sv
      - design/regfile.sv
      - design/alu.sv
      - design/exec_unit.sv
      - design/la32_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/la32_monitor.sv
      - verif/la32_chk.sv
      - verif/la32_tb.sv

// File: design/alu.sv
`timescale 1ns/1ps

module alu
    import la32_pkg::*;
(
    input  alu_op_e     op,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    output logic [31:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            ALU_AND:  result = src1 & src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            ALU_LUI:  result = src2; // immediate already shifted.
            default:  result = '0;
        endcase
    end

endmodule

// File: design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import la32_pkg::*;
(
    input  ctrl_t       ctrl,
    input  logic [31:0] pc,
    input  logic [31:0] rj_val,
    input  logic [31:0] rkd_val,
    output exec_res_t   res
);

    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;
    logic [31:0] seq_pc;
    logic        rj_eq_rd;
    logic        links;

    assign src1     = ctrl.src1_is_pc ? pc : rj_val;
    assign src2     = ctrl.src2_is_imm ? ctrl.imm : rkd_val;
    assign seq_pc   = pc + 32'd4;
    assign rj_eq_rd = (rj_val == rkd_val);
    assign links    = (ctrl.br_kind == BR_BL) || (ctrl.br_kind == BR_JIRL);

    // also forms branch targets and load/store addresses.
    alu alu_i (
        .op     (ctrl.alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    always_comb begin
        case (ctrl.br_kind)
            BR_B, BR_BL, BR_JIRL: res.br_taken = 1'b1;
            BR_BEQ:               res.br_taken = rj_eq_rd;
            BR_BNE:               res.br_taken = !rj_eq_rd;
            default:              res.br_taken = 1'b0;
        endcase
        res.br_target = alu_result;
        res.mem_addr  = {alu_result[31:2], 2'b00}; // word access only.
        res.result    = links ? seq_pc : alu_result;
    end

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import la32_pkg::*;
(
    input  inst_word_u inst,
    output ctrl_t      ctrl,
    output logic [4:0] raddr1,
    output logic [4:0] raddr2
);

    logic [31:0] offs16;
    logic [31:0] offs26;
    logic [31:0] sext12;
    logic        src2_is_rd;

    assign offs16 = {{14{inst.ri16.si16[15]}}, inst.ri16.si16, 2'b00};
    // b and bl carry offs[25:16] in the rj/rd slots.
    assign offs26 = {{4{inst.ri16.rj[4]}}, inst.ri16.rj, inst.ri16.rd, inst.ri16.si16, 2'b00};
    assign sext12 = {{20{inst.ri12.si12[11]}}, inst.ri12.si12};

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = ALU_ADD;
        ctrl.br_kind = BR_NONE;
        ctrl.dest    = inst.rrr.rd;
        src2_is_rd   = 1'b0;

        // the four opcode spaces do not overlap.
        case (inst.rrr.opcode)
            17'h00020: {ctrl.alu_op, ctrl.reg_write} = {ALU_ADD, 1'b1};
            17'h00022: {ctrl.alu_op, ctrl.reg_write} = {ALU_SUB, 1'b1};
            17'h00024: {ctrl.alu_op, ctrl.reg_write} = {ALU_SLT, 1'b1};
            17'h00025: {ctrl.alu_op, ctrl.reg_write} = {ALU_SLTU, 1'b1};
            17'h00028: {ctrl.alu_op, ctrl.reg_write} = {ALU_NOR, 1'b1};
            17'h00029: {ctrl.alu_op, ctrl.reg_write} = {ALU_AND, 1'b1};
            17'h0002a: {ctrl.alu_op, ctrl.reg_write} = {ALU_OR, 1'b1};
            17'h0002b: {ctrl.alu_op, ctrl.reg_write} = {ALU_XOR, 1'b1};
            17'h00081, 17'h00089, 17'h00091: begin
                ctrl.alu_op      = (inst.rrr.opcode[4:3] == 2'b00) ? ALU_SLL :
                                   (inst.rrr.opcode[4:3] == 2'b01) ? ALU_SRL : ALU_SRA;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = {27'b0, inst.rrr.rk}; // ui5.
                ctrl.reg_write   = 1'b1;
            end
            default: ;
        endcase

        case (inst.ri12.opcode)
            10'h00a, 10'h0a2, 10'h0a6: begin // addi.w, ld.w, st.w.
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = sext12;
                ctrl.mem_read    = (inst.ri12.opcode == 10'h0a2);
                ctrl.mem_write   = (inst.ri12.opcode == 10'h0a6);
                ctrl.reg_write   = (inst.ri12.opcode != 10'h0a6);
                src2_is_rd       = (inst.ri12.opcode == 10'h0a6);
            end
            default: ;
        endcase

        case (inst.ri16.opcode)
            6'h13: begin
                ctrl.br_kind     = BR_JIRL;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = offs16; // target from rj.
                ctrl.reg_write   = 1'b1;
            end
            6'h14, 6'h15: begin
                ctrl.br_kind     = (inst.ri16.opcode[0]) ? BR_BL : BR_B;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = offs26;
                ctrl.reg_write   = inst.ri16.opcode[0];
                ctrl.dest        = (inst.ri16.opcode[0]) ? 5'd1 : inst.ri16.rd;
            end
            6'h16, 6'h17: begin
                ctrl.br_kind     = (inst.ri16.opcode[0]) ? BR_BNE : BR_BEQ;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = offs16;
                src2_is_rd       = 1'b1;
            end
            default: ;
        endcase

        if (inst.ri20.opcode == 7'h0a) begin // lu12i.w.
            ctrl.alu_op      = ALU_LUI;
            ctrl.src2_is_imm = 1'b1;
            ctrl.imm         = {inst.ri20.si20, 12'b0};
            ctrl.reg_write   = 1'b1;
        end
    end

    assign raddr1 = inst.rrr.rj;
    assign raddr2 = src2_is_rd ? inst.rrr.rd : inst.rrr.rk;

endmodule

// File: design/la32_core.sv
`timescale 1ns/1ps
`include "la32_defines.svh"

module la32_core
    import la32_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    output logic        data_we,
    output logic [31:0] data_addr,
    output logic [31:0] data_wdata,
    input  logic [31:0] data_rdata,
    output logic [31:0] trace_pc,
    output logic        trace_we,
    output logic [4:0]  trace_wnum,
    output logic [31:0] trace_wdata
);

    core_state_e state;
    core_state_e state_next;
    logic [31:0] pc;
    logic [31:0] inst_pc_q;
    ctrl_t       dec_ctrl;
    ctrl_t       ctrl_q;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] rj_q;
    logic [31:0] rkd_q;
    exec_res_t   ex_res;
    logic [31:0] ex_result_q;
    logic [31:0] load_data_q;
    logic [31:0] wb_data;
    logic        no_wb;

    inst_decoder decoder_i (
        .inst   (inst_rdata),
        .ctrl   (dec_ctrl),
        .raddr1 (raddr1),
        .raddr2 (raddr2)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .raddr2 (raddr2),
        .rdata2 (rdata2),
        .we     (trace_we),
        .waddr  (ctrl_q.dest),
        .wdata  (wb_data)
    );

    exec_unit exec_i (
        .ctrl    (ctrl_q),
        .pc      (pc),
        .rj_val  (rj_q),
        .rkd_val (rkd_q),
        .res     (ex_res)
    );

    // b, beq, bne and st.w finish in EX.
    assign no_wb = ctrl_q.mem_write || (ctrl_q.br_kind inside {BR_B, BR_BEQ, BR_BNE});

    always_comb begin
        case (state)
            ST_IF:   state_next = ST_ID;
            ST_ID:   state_next = ST_EX;
            ST_EX:   state_next = ctrl_q.mem_read ? ST_MEM : (no_wb ? ST_IF : ST_WB);
            ST_MEM:  state_next = ST_WB;
            default: state_next = ST_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IF;
            pc       <= `LA32_RESET_PC;
            data_we  <= 1'b0;
            trace_we <= 1'b0;
        end else begin
            state    <= state_next;
            data_we  <= (state == ST_ID) && dec_ctrl.mem_write; // high through EX.
            trace_we <= (state_next == ST_WB) && ctrl_q.reg_write;
            if (state == ST_EX) begin
                pc <= ex_res.br_taken ? ex_res.br_target : pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_ID) begin
            ctrl_q    <= dec_ctrl;
            rj_q      <= rdata1;
            rkd_q     <= rdata2;
            inst_pc_q <= pc;
        end
        if (state == ST_EX) begin
            ex_result_q <= ex_res.result;
        end
        if (state == ST_MEM) begin
            load_data_q <= data_rdata;
        end
    end

    assign wb_data = ctrl_q.mem_read ? load_data_q : ex_result_q;

    assign inst_addr   = pc;
    assign data_addr   = ex_res.mem_addr;
    assign data_wdata  = rkd_q;
    assign trace_pc    = inst_pc_q;
    assign trace_wnum  = ctrl_q.dest;
    assign trace_wdata = wb_data;

endmodule

// File: design/la32_defines.svh
`ifndef LA32_DEFINES_SVH
`define LA32_DEFINES_SVH

// first fetch address after reset.
`define LA32_RESET_PC 32'h1c00_0000

// integer data path width.
`define LA32_XLEN 32

// architectural general registers.
`define LA32_NREGS 32

`endif

// File: design/la32_pkg.sv
`include "la32_defines.svh"

package la32_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_B, BR_BL, BR_BEQ, BR_BNE, BR_JIRL
    } br_kind_e;

    typedef enum logic [2:0] {
        ST_IF, ST_ID, ST_EX, ST_MEM, ST_WB
    } core_state_e;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } rrr_fmt_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] si16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri16_fmt_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        logic [4:0]  rd;
    } ri20_fmt_t;

    typedef union packed {
        rrr_fmt_t  rrr;
        ri12_fmt_t ri12;
        ri16_fmt_t ri16;
        ri20_fmt_t ri20;
    } inst_word_u;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic [`LA32_XLEN-1:0] imm;
        br_kind_e              br_kind;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic [4:0]            dest;
    } ctrl_t;

    typedef struct packed {
        logic [`LA32_XLEN-1:0] result;
        logic                  br_taken;
        logic [`LA32_XLEN-1:0] br_target;
        logic [`LA32_XLEN-1:0] mem_addr;
    } exec_res_t;

endpackage

// File: design/regfile.sv
`timescale 1ns/1ps
`include "la32_defines.svh"

module regfile (
    input  logic                  clk,
    input  logic [4:0]            raddr1,
    output logic [`LA32_XLEN-1:0] rdata1,
    input  logic [4:0]            raddr2,
    output logic [`LA32_XLEN-1:0] rdata2,
    input  logic                  we,
    input  logic [4:0]            waddr,
    input  logic [`LA32_XLEN-1:0] wdata
);

    logic [`LA32_XLEN-1:0] regs [`LA32_NREGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero.
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: files.f
+incdir+design
design/la32_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/alu.sv
design/exec_unit.sv
design/la32_core.sv
verif/la32_monitor.sv
verif/la32_chk.sv
verif/la32_tb.sv

// File: verif/la32_chk.sv
`timescale 1ns/1ps

module la32_chk (
    input logic clk,
    input logic reset,
    input logic data_we,
    input logic trace_we
);

    int failures = 0;

    // strobes stay low after every reset cycle, the first free cycle included.
    quiet_after_reset: assert property (@(posedge clk) reset |=> !data_we && !trace_we)
        else begin
            $error("store or trace strobe high right after a reset cycle");
            failures++;
        end

    store_single_cycle: assert property (
        @(posedge clk) disable iff (reset) data_we |=> !data_we)
        else begin
            $error("data_we high on two consecutive cycles");
            failures++;
        end

    trace_spacing: assert property (
        @(posedge clk) disable iff (reset) trace_we |=> !trace_we [*3])
        else begin
            $error("trace_we fired twice within four cycles");
            failures++;
        end

endmodule

bind la32_core la32_chk chk_i (
    .clk      (clk),
    .reset    (reset),
    .data_we  (data_we),
    .trace_we (trace_we)
);

// File: verif/la32_monitor.sv
`timescale 1ns/1ps
`include "la32_defines.svh"

module la32_monitor #(
    parameter int IMEM_WORDS = 512,
    parameter int DMEM_WORDS = 512
) (
    input logic        clk,
    input logic        reset,
    input logic        trace_we,
    input logic [31:0] trace_pc,
    input logic [4:0]  trace_wnum,
    input logic [31:0] trace_wdata,
    input logic [31:0] prog [IMEM_WORDS],
    input logic [31:0] data_image [DMEM_WORDS]
);

    logic [31:0] regs [`LA32_NREGS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] pc;
    logic        halted;
    int          writes;
    int          errors;

    task automatic start_model();
        for (int i = 0; i < `LA32_NREGS; i++) begin
            regs[i] = '0;
        end
        dmem   = data_image; // private copy, the DUT stores into the tb array.
        pc     = `LA32_RESET_PC;
        halted = 1'b0;
        writes = 0;
        errors = 0;
    endtask

    // executes one instruction at pc.
    task automatic step_model(output logic wr, output logic [4:0] wnum,
                              output logic [31:0] wdata, output logic [31:0] ipc);
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] dv;
        logic [31:0] npc;
        logic [31:0] addr;
        logic [31:0] offs16;
        logic [31:0] offs26;
        inst   = prog[((pc - `LA32_RESET_PC) >> 2) % IMEM_WORDS];
        a      = regs[inst[9:5]];
        b      = regs[inst[14:10]];
        dv     = regs[inst[4:0]];
        addr   = a + {{20{inst[21]}}, inst[21:10]};
        offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        ipc    = pc;
        npc    = pc + 32'd4;
        wr     = 1'b1;
        wnum   = inst[4:0];
        wdata  = '0;
        casez (inst[31:15])
            17'h00020: wdata = a + b;
            17'h00022: wdata = a - b;
            17'h00024: wdata = {31'b0, $signed(a) < $signed(b)};
            17'h00025: wdata = {31'b0, a < b};
            17'h00028: wdata = ~(a | b);
            17'h00029: wdata = a & b;
            17'h0002a: wdata = a | b;
            17'h0002b: wdata = a ^ b;
            17'h00081: wdata = a << inst[14:10];
            17'h00089: wdata = a >> inst[14:10];
            17'h00091: wdata = $signed(a) >>> inst[14:10];
            17'b0000001010_???????: wdata = addr; // addi.w.
            17'b0010100010_???????: wdata = dmem[(addr >> 2) % DMEM_WORDS];
            17'b0010100110_???????: begin
                wr = 1'b0;
                dmem[(addr >> 2) % DMEM_WORDS] = dv;
            end
            17'b0001010_??????????: wdata = {inst[24:5], 12'b0};
            17'b010011_???????????: begin // jirl.
                wdata = pc + 32'd4;
                npc   = a + offs16;
            end
            17'b010100_???????????: begin
                wr  = 1'b0;
                npc = pc + offs26;
            end
            17'b010101_???????????: begin // bl links into r1.
                wnum  = 5'd1;
                wdata = pc + 32'd4;
                npc   = pc + offs26;
            end
            17'b010110_???????????: begin
                wr = 1'b0;
                if (a == dv) npc = pc + offs16;
            end
            17'b010111_???????????: begin
                wr = 1'b0;
                if (a != dv) npc = pc + offs16;
            end
            default: wr = 1'b0;
        endcase
        if (wr && wnum != 5'd0) regs[wnum] = wdata;
        halted = (npc == pc); // final self-loop.
        pc     = npc;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic compare_write();
        logic        wr;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        logic [31:0] ipc;
        wr = 1'b0;
        for (int n = 0; n < IMEM_WORDS && !wr && !halted; n++) begin
            step_model(wr, wnum, wdata, ipc);
        end
        if (!wr) begin
            $display("%0t: register write at pc %h where the model expects none", $time, trace_pc);
            errors++;
        end else begin
            check_value("trace_pc", ipc, trace_pc);
            check_value("trace_wnum", {27'b0, wnum}, {27'b0, trace_wnum});
            check_value("trace_wdata", wdata, trace_wdata);
        end
        writes++;
    endtask

    always @(negedge clk) begin
        if (!reset && trace_we) compare_write();
    end

    // runs the model to its self-loop, counts writes never seen, then compares data memory.
    task automatic finish_test(output int nwrites, output int nerrors);
        logic        wr;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        logic [31:0] ipc;
        int          pending;
        pending = 0;
        for (int n = 0; n < IMEM_WORDS && !halted; n++) begin
            step_model(wr, wnum, wdata, ipc);
            if (wr) pending++;
        end
        if (pending != 0) begin
            $display("%0t: %0d expected register writes never reached the trace port",
                     $time, pending);
            errors++;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[i], data_image[i]);
        end
        nwrites = writes;
        nerrors = errors;
    endtask

endmodule

// File: verif/la32_tb.sv
`timescale 1ns/1ps
`include "la32_defines.svh"

module la32_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_WORDS    = 512;
    localparam int NUM_TESTS    = 5;
    localparam int INIT_INSTS   = 30;
    localparam int TOTAL_INSTS  = 20 + 200 + 150 + 150 + 300 + (INIT_INSTS + 2) * NUM_TESTS;
    localparam int WATCHDOG_CYCLES = 5 * TOTAL_INSTS * 2 + RESET_CYCLES * NUM_TESTS;

    logic        clk;
    logic        reset;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic [31:0] trace_pc;
    logic        trace_we;
    logic [4:0]  trace_wnum;
    logic [31:0] trace_wdata;
    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] inst_addr_q;
    logic [31:0] data_addr_q;
    int          total_errors;
    int          failed_tests;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    la32_core dut_i (.*);

    la32_monitor #(.IMEM_WORDS(MEM_WORDS), .DMEM_WORDS(MEM_WORDS)) monitor_i (
        .clk         (clk),
        .reset       (reset),
        .trace_we    (trace_we),
        .trace_pc    (trace_pc),
        .trace_wnum  (trace_wnum),
        .trace_wdata (trace_wdata),
        .prog        (imem),
        .data_image  (dmem)
    );

    // synchronous SRAMs, data out on the falling edge.
    always @(posedge clk) begin
        inst_addr_q <= inst_addr;
        data_addr_q <= data_addr;
        if (data_we) dmem[data_addr[10:2]] <= data_wdata;
    end

    always @(negedge clk) begin
        inst_rdata <= imem[inst_addr_q[10:2]];
        data_rdata <= dmem[data_addr_q[10:2]];
    end

    function automatic logic [31:0] enc_ri12(logic [9:0] op, logic [11:0] si12,
                                             logic [4:0] rj, logic [4:0] rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri16(logic [5:0] op, logic [15:0] si16,
                                             logic [4:0] rj, logic [4:0] rd);
        return {op, si16, rj, rd};
    endfunction

    // b and bl keep offs[25:16] in the low ten bits.
    function automatic logic [31:0] enc_b26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] random_inst(int idx, int last, int mix);
        logic [16:0] rrr_ops [8] = '{17'h00020, 17'h00022, 17'h00024, 17'h00025,
                                     17'h00028, 17'h00029, 17'h0002a, 17'h0002b};
        logic [16:0] sh_ops [3] = '{17'h00081, 17'h00089, 17'h00091};
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [11:0] woff;
        logic [25:0] offs;
        int          kind;
        rd    = 5'($urandom_range(30));
        rd    = (rd == 5'd30) ? 5'd31 : rd; // r30 holds the base.
        rj    = 5'($urandom_range(31));
        rk    = 5'($urandom_range(31));
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        woff  = {1'b0, 9'($urandom_range(MEM_WORDS - 1)), 2'b00};
        offs  = 26'($urandom_range((last - idx < 8) ? last - idx : 8, 1));
        case (mix)
            0: kind = $urandom_range(12);
            1: kind = $urandom_range(1) ? $urandom_range(14, 13) : $urandom_range(12);
            2: kind = $urandom_range(1) ? $urandom_range(19, 15) : $urandom_range(12);
            default: kind = $urandom_range(19);
        endcase
        if (kind >= 17 && $urandom_range(1)) rk = rj; // equal operands.
        case (kind)
            0, 1, 2, 3, 4, 5, 6, 7: return {rrr_ops[kind], rk, rj, rd};
            8, 9, 10: return {sh_ops[kind - 8], rk, rj, rd};
            11: return enc_ri12(10'h00a, imm12, rj, rd);
            12: return {7'h0a, imm20, rd};
            13: return enc_ri12(10'h0a2, woff, 5'd0, rd);
            14: return enc_ri12(10'h0a6, woff, 5'd0, rk);
            15: return enc_b26(6'h14, offs);
            16: return enc_b26(6'h15, offs);
            17: return enc_ri16(6'h16, offs[15:0], rj, rk);
            18: return enc_ri16(6'h17, offs[15:0], rj, rk);
            default: return enc_ri16(6'h13, 16'(idx + offs), 5'd30, rd); // jirl.
        endcase
    endfunction

    task automatic build_program(input int n, input int mix);
        logic [31:0] base;
        int          last;
        base = `LA32_RESET_PC;
        last = INIT_INSTS + n + 1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = $urandom;
        end
        imem[0] = {7'h0a, base[31:12], 5'd30}; // lu12i.w r30.
        // every other register gets a known value before the body reads it.
        for (int r = 1; r <= INIT_INSTS; r++) begin
            imem[r] = enc_ri12(10'h00a, 12'($urandom), 5'd0, (r == 30) ? 5'd31 : 5'(r));
        end
        for (int i = INIT_INSTS + 1; i < last; i++) begin
            imem[i] = random_inst(i, last, mix);
        end
        imem[last] = enc_b26(6'h14, 26'd0);
    endtask

    task automatic run_test(input int num, input string name, input int n, input int mix);
        logic [31:0] last_addr;
        int          stable;
        int          writes;
        int          errs;
        int          early;
        int          chk_base;
        early     = 0;
        chk_base  = dut_i.chk_i.failures;
        last_addr = `LA32_RESET_PC + 4 * (INIT_INSTS + n + 1);
        reset     = 1'b1;
        build_program(n, mix);
        repeat (RESET_CYCLES) @(negedge clk);
        monitor_i.start_model();
        reset = 1'b0;
        @(negedge clk);
        if (inst_addr !== `LA32_RESET_PC) begin
            $display("ERROR %0t inst_addr: expected %h, got %h", $time, `LA32_RESET_PC, inst_addr);
            early++;
        end
        repeat (2) begin
            if (data_we !== 1'b0 || trace_we !== 1'b0) begin
                $display("%0t: store or register write before the first write-back", $time);
                early++;
            end
            @(negedge clk);
        end
        stable = 0;
        while (stable < 6) begin // two passes of the 3-cycle self-loop.
            @(negedge clk);
            stable = (inst_addr == last_addr) ? stable + 1 : 0;
        end
        monitor_i.finish_test(writes, errs);
        errs += early + dut_i.chk_i.failures - chk_base;
        $display("test %0d %s: %s, %0d register writes, %0d errors",
                 num, name, (errs == 0) ? "passed" : "failed", writes, errs);
        total_errors += errs;
        if (errs != 0) failed_tests++;
    endtask

    initial begin
        void'($urandom(20381));
        reset        = 1'b1;
        inst_rdata   = '0;
        data_rdata   = '0;
        total_errors = 0;
        failed_tests = 0;
        run_test(1, "reset", 20, 0);
        run_test(2, "alu program", 200, 0);
        run_test(3, "loads and stores", 150, 1);
        run_test(4, "control flow", 150, 2);
        run_test(5, "mixed program", 300, 3);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the core did not reach the final self-loop within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
